// File: Makefile
# Verilator run of the rhythm_audio testbench, result taken from sim.log
TOP = tb_rhythm_audio

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f rhythm_audio.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -x -F '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: logic/i2s_serializer.sv
// I2S transmitter, 16 bit mono duplicated to both channels; 32 bclk frames, zeros on underrun
`timescale 1ns/1ps
`include "rhythm_audio_params.svh"

module i2s_serializer (
	input  logic                      MAX10_CLK1_50,
	input  logic                      reset_i,
	input  logic                      play_start_i,
	input  logic                      fetch_done_i, // fetcher has nothing more
	input  logic                      fifo_empty_i,
	input  rhythm_audio_pkg::sample_t fifo_head_i,
	output logic                      pop_o,
	output logic                      playing_o,
	output logic                      bclk_o,
	output logic                      lrclk_o,      // low = left
	output logic                      data_o
);

	localparam int DIV_W = $clog2(`RA_BCLK_HALF) + 1;
	localparam int MSB   = `RA_SAMPLE_W - 1;

	logic             running_q; // frames going, bclk toggling
	logic [DIV_W-1:0] div_q;
	logic [4:0]       slot_q;    // bit slot in frame, 0..31
	rhythm_audio_pkg::sample_t sample_q; // kept for the right word
	rhythm_audio_pkg::sample_t shift_q;

	logic tick, fall, frame_edge, stop;
	rhythm_audio_pkg::sample_t word;

	// ========================================
	// frame timing
	// ========================================
	assign tick = running_q && (div_q == DIV_W'(`RA_BCLK_HALF - 1));
	assign fall = tick && bclk_o; // bclk about to go low

	// frame starts at slot 31 end, or while waiting for the first sample
	assign frame_edge = (fall && (slot_q == 5'd31)) || (playing_o && !running_q);
	assign stop       = frame_edge && fetch_done_i && fifo_empty_i;

	assign pop_o = frame_edge && !fifo_empty_i;
	assign word  = fifo_empty_i ? '0 : fifo_head_i; // underrun sends silence

	always_ff @(posedge MAX10_CLK1_50) begin
		if (reset_i) begin
			playing_o <= 1'b0;
			running_q <= 1'b0;
			div_q     <= '0;
			slot_q    <= '0;
			bclk_o    <= 1'b0;
			lrclk_o   <= 1'b0;
			data_o    <= 1'b0;
		end else if (!playing_o) begin
			if (play_start_i)
				playing_o <= 1'b1;    // idle until first sample arrives
		end else if (stop) begin
			playing_o <= 1'b0;        // last right word already out
			running_q <= 1'b0;
			bclk_o    <= 1'b0;
			lrclk_o   <= 1'b0;
			data_o    <= 1'b0;
		end else if (frame_edge && (running_q || !fifo_empty_i)) begin
			running_q <= 1'b1;
			div_q     <= '0;
			slot_q    <= '0;
			bclk_o    <= 1'b0;
			lrclk_o   <= 1'b0;        // left word
			data_o    <= word[MSB];
		end else if (tick) begin
			div_q  <= '0;
			bclk_o <= ~bclk_o;
			if (bclk_o) begin         // falling edge, next bit
				slot_q  <= slot_q + 5'd1;
				// ws leads the MSB by one bit
				lrclk_o <= (slot_q >= 5'd14) && (slot_q <= 5'd29);
				if (slot_q == 5'd15)
					data_o <= sample_q[MSB]; // right MSB
				else
					data_o <= shift_q[MSB];
			end
		end else if (running_q) begin
			div_q <= div_q + 1'b1;
		end
	end

	// ========================================
	// shift path
	// ========================================
	always_ff @(posedge MAX10_CLK1_50) begin
		if (frame_edge) begin
			sample_q <= word;
			shift_q  <= {word[MSB-1:0], 1'b0};
		end else if (fall) begin
			if (slot_q == 5'd15)
				shift_q <= {sample_q[MSB-1:0], 1'b0}; // reload for right
			else
				shift_q <= {shift_q[MSB-1:0], 1'b0};
		end
	end

endmodule

// File: logic/mem_arbiter.sv
// two-way arbiter for the sample store; loader wins ties, one owner per access, no preemption
`timescale 1ns/1ps

module mem_arbiter (
	input  logic               MAX10_CLK1_50,
	input  logic               reset_i,
	mem_port_if.responder      load_port,  // sd loader stand-in
	mem_port_if.responder      fetch_port, // playback reads
	mem_port_if.requester      ram_port    // to sample_ram
);

	// ========================================
	// owner state
	// ========================================
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_LOAD,
		OWN_FETCH
	} owner_e;

	owner_e owner_q;

	// grant only from idle so a second request
	// can't slip in halfway through an access
	always_ff @(posedge MAX10_CLK1_50) begin
		if (reset_i) begin
			owner_q <= OWN_NONE;
		end else begin
			case (owner_q)
				OWN_NONE: begin
					if (load_port.req)
						owner_q <= OWN_LOAD;  // loader priority
					else if (fetch_port.req)
						owner_q <= OWN_FETCH;
				end
				default: begin
					if (ram_port.ack)
						owner_q <= OWN_NONE;  // free again next cycle
				end
			endcase
		end
	end

	// ========================================
	// request forwarding
	// ========================================
	always_comb begin
		ram_port.req   = 1'b0;
		ram_port.we    = 1'b0;
		ram_port.addr  = '0;
		ram_port.wdata = '0;
		case (owner_q)
			OWN_LOAD: begin
				ram_port.req   = load_port.req;
				ram_port.we    = load_port.we;
				ram_port.addr  = load_port.addr;
				ram_port.wdata = load_port.wdata;
			end
			OWN_FETCH: begin
				ram_port.req   = fetch_port.req;
				ram_port.we    = fetch_port.we;
				ram_port.addr  = fetch_port.addr;
				ram_port.wdata = fetch_port.wdata;
			end
			default: ; // idle, port quiet
		endcase
	end

	// ack and read data go back to the owner only
	assign load_port.ack    = (owner_q == OWN_LOAD) && ram_port.ack;
	assign load_port.rdata  = (owner_q == OWN_LOAD) ? ram_port.rdata : '0;
	assign fetch_port.ack   = (owner_q == OWN_FETCH) && ram_port.ack;
	assign fetch_port.rdata = (owner_q == OWN_FETCH) ? ram_port.rdata : '0;

endmodule

// File: logic/mem_port_if.sv
// single request/ack memory port; requester holds req and fields stable until the ack pulse
`timescale 1ns/1ps

interface mem_port_if;

	// request side
	logic                     req;   // level, held until ack
	logic                     we;    // 1 = write, 0 = read
	rhythm_audio_pkg::addr_t  addr;  // word address
	rhythm_audio_pkg::sample_t wdata; // write payload

	// response side
	logic                     ack;   // one cycle pulse
	rhythm_audio_pkg::sample_t rdata; // valid in the ack cycle

	// whoever starts an access
	modport requester (
		output req, we, addr, wdata,
		input  ack, rdata
	);

	// whoever answers it
	modport responder (
		input  req, we, addr, wdata,
		output ack, rdata
	);

endinterface

// File: logic/rhythm_audio.sv
// sound path top; loader writes and playback share one memory, load_wr_i must be held until load_ack_o
`timescale 1ns/1ps
`include "rhythm_audio_params.svh"

module rhythm_audio (
	input  logic                      MAX10_CLK1_50,
	input  logic                      reset_i,
	input  logic                      load_wr_i,      // held until ack
	input  rhythm_audio_pkg::addr_t   load_addr_i,
	input  rhythm_audio_pkg::sample_t load_data_i,
	output logic                      load_ack_o,
	input  logic                      play_start_i,   // one cycle pulse
	input  rhythm_audio_pkg::addr_t   sample_count_i,
	output logic                      playing_o,
	output logic                      i2s_bclk_o,
	output logic                      i2s_lrclk_o,
	output logic                      i2s_data_o
);

	// ========================================
	// memory ports
	// ========================================
	mem_port_if load_port ();
	mem_port_if fetch_port ();
	mem_port_if ram_port ();

	// loader is write only
	assign load_port.req   = load_wr_i;
	assign load_port.we    = 1'b1;
	assign load_port.addr  = load_addr_i;
	assign load_port.wdata = load_data_i;
	assign load_ack_o      = load_port.ack;

	// FIFO link
	logic                      push, pop, fifo_empty, fetch_done;
	rhythm_audio_pkg::sample_t push_data, fifo_head;
	logic [`RA_FIFO_CNT_W-1:0] fifo_cnt;

	mem_arbiter i_arbiter (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.reset_i       (reset_i),
		.load_port     (load_port),
		.fetch_port    (fetch_port),
		.ram_port      (ram_port)
	);

	sample_ram i_ram (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.reset_i       (reset_i),
		.ram_port      (ram_port)
	);

	sample_fetcher i_fetcher (
		.MAX10_CLK1_50  (MAX10_CLK1_50),
		.reset_i        (reset_i),
		.play_start_i   (play_start_i),
		.sample_count_i (sample_count_i),
		.fetch_port     (fetch_port),
		.fifo_cnt_i     (fifo_cnt),
		.push_o         (push),
		.push_data_o    (push_data),
		.fetch_done_o   (fetch_done)
	);

	sample_fifo i_fifo (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.reset_i       (reset_i),
		.push_i        (push),
		.push_data_i   (push_data),
		.pop_i         (pop),
		.head_o        (fifo_head),
		.empty_o       (fifo_empty),
		.cnt_o         (fifo_cnt)
	);

	i2s_serializer i_i2s (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.reset_i       (reset_i),
		.play_start_i  (play_start_i),
		.fetch_done_i  (fetch_done),
		.fifo_empty_i  (fifo_empty),
		.fifo_head_i   (fifo_head),
		.pop_o         (pop),
		.playing_o     (playing_o),
		.bclk_o        (i2s_bclk_o),
		.lrclk_o       (i2s_lrclk_o),
		.data_o        (i2s_data_o)
	);

endmodule

// File: logic/rhythm_audio_params.svh
// sizes for the sound path; RA_FIFO_DEPTH must be a power of two and RA_RAM_WAIT at least 1
`ifndef RHYTHM_AUDIO_PARAMS_SVH
`define RHYTHM_AUDIO_PARAMS_SVH

// ========================================
// sample and memory geometry
// ========================================
`define RA_SAMPLE_W    16 // bits per audio sample
`define RA_ADDR_W      10 // 1024 word sample store

// ========================================
// buffering and timing
// ========================================
`define RA_FIFO_DEPTH  8  // playback FIFO entries
`define RA_FIFO_CNT_W  4  // holds 0..RA_FIFO_DEPTH

// stand-in for the SDRAM controller latency
`define RA_RAM_WAIT    3  // cycles from accept to ack
`define RA_BCLK_HALF   2  // system clocks per bit clock half period

`endif

// File: logic/rhythm_audio_pkg.sv
// shared payload types; widths come from the params header, nothing here is synthesized alone
`include "rhythm_audio_params.svh"

package rhythm_audio_pkg;

	// ========================================
	// payload types
	// ========================================

	// one mono audio sample, signed PCM as stored
	// the path never does arithmetic on it
	typedef logic [`RA_SAMPLE_W-1:0] sample_t;

	// word address into the sample store
	typedef logic [`RA_ADDR_W-1:0] addr_t; // also used as the sample count

endpackage

// File: logic/sample_fetcher.sv
// playback reader; walks from address 0 for sample_count_i words, one read in flight, restart only when idle
`timescale 1ns/1ps
`include "rhythm_audio_params.svh"

module sample_fetcher (
	input  logic                         MAX10_CLK1_50,
	input  logic                         reset_i,
	input  logic                         play_start_i,   // one cycle start pulse
	input  rhythm_audio_pkg::addr_t      sample_count_i, // words to play
	mem_port_if.requester                fetch_port,
	input  logic [`RA_FIFO_CNT_W-1:0]    fifo_cnt_i,     // FIFO occupancy
	output logic                         push_o,
	output rhythm_audio_pkg::sample_t    push_data_o,
	output logic                         fetch_done_o    // nothing left to read
);

	localparam int CNT_W = `RA_FIFO_CNT_W;

	rhythm_audio_pkg::addr_t next_addr_q; // address of the next read
	rhythm_audio_pkg::addr_t remain_q;    // reads still to issue
	logic                    pending_q;   // read in flight, drives req

	logic [CNT_W:0] used;   // occupancy plus reads in flight
	logic           room;
	logic           issue;

	// ========================================
	// flow control
	// ========================================
	assign used  = {1'b0, fifo_cnt_i} + (CNT_W + 1)'(pending_q);
	assign room  = used < (CNT_W + 1)'(`RA_FIFO_DEPTH);
	assign issue = !pending_q && (remain_q != '0) && room;

	always_ff @(posedge MAX10_CLK1_50) begin
		if (reset_i) begin
			next_addr_q <= '0;
			remain_q    <= '0;
			pending_q   <= 1'b0;
		end else begin
			if (play_start_i) begin
				next_addr_q <= '0;          // stream always from word 0
				remain_q    <= sample_count_i;
			end else if (fetch_port.ack) begin
				next_addr_q <= next_addr_q + 1'b1;
				remain_q    <= remain_q - 1'b1;
			end
			// req drops the cycle after ack
			if (fetch_port.ack)
				pending_q <= 1'b0;
			else if (issue && !play_start_i)
				pending_q <= 1'b1;
		end
	end

	// read only port
	assign fetch_port.req   = pending_q;
	assign fetch_port.we    = 1'b0;
	assign fetch_port.addr  = next_addr_q; // stable while pending
	assign fetch_port.wdata = '0;

	// read data straight into the FIFO in the ack cycle
	assign push_o      = fetch_port.ack;
	assign push_data_o = fetch_port.rdata;

	assign fetch_done_o = (remain_q == '0) && !pending_q;

endmodule

// File: logic/sample_fifo.sv
// single clock sample FIFO; depth must be a power of two, push when full and pop when empty are dropped
`timescale 1ns/1ps
`include "rhythm_audio_params.svh"

module sample_fifo (
	input  logic                      MAX10_CLK1_50,
	input  logic                      reset_i,
	input  logic                      push_i,
	input  rhythm_audio_pkg::sample_t push_data_i,
	input  logic                      pop_i,
	output rhythm_audio_pkg::sample_t head_o,  // oldest entry
	output logic                      empty_o,
	output logic [`RA_FIFO_CNT_W-1:0] cnt_o    // occupancy
);

	localparam int PTR_W = $clog2(`RA_FIFO_DEPTH);
	localparam int CNT_W = `RA_FIFO_CNT_W;

	rhythm_audio_pkg::sample_t mem_q [`RA_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q; // wrap naturally
	logic             do_push, do_pop;

	assign do_pop  = pop_i && (cnt_o != '0);
	assign do_push = push_i && (cnt_o != CNT_W'(`RA_FIFO_DEPTH));

	// ========================================
	// pointers and occupancy
	// ========================================
	always_ff @(posedge MAX10_CLK1_50) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_o    <= '0;
		end else begin
			if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_push, do_pop})
				2'b10:   cnt_o <= cnt_o + 1'b1;
				2'b01:   cnt_o <= cnt_o - 1'b1;
				default: ; // both or neither, count holds
			endcase
		end
	end

	always_ff @(posedge MAX10_CLK1_50) begin
		if (do_push)
			mem_q[wr_ptr_q] <= push_data_i;
	end

	assign head_o  = mem_q[rd_ptr_q]; // new push shows here a cycle later
	assign empty_o = (cnt_o == '0);

endmodule

// File: logic/sample_ram.sv
// on-chip stand-in for the SDRAM; fixed RA_RAM_WAIT latency, one access at a time, contents undefined at power up
`timescale 1ns/1ps
`include "rhythm_audio_params.svh"

module sample_ram (
	input  logic          MAX10_CLK1_50,
	input  logic          reset_i,
	mem_port_if.responder ram_port
);

	localparam int WAIT_W = $clog2(`RA_RAM_WAIT) + 1;

	rhythm_audio_pkg::sample_t mem_q [2**`RA_ADDR_W]; // word store
	rhythm_audio_pkg::sample_t rdata_q;               // read captured at accept

	logic              busy_q;  // access in progress
	logic [WAIT_W-1:0] wait_q;  // cycles left until ack
	logic              accept;

	assign accept = !busy_q && ram_port.req; // take a request only when idle

	// ========================================
	// wait counter
	// ========================================
	always_ff @(posedge MAX10_CLK1_50) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			wait_q <= '0;
		end else if (accept) begin
			busy_q <= 1'b1;
			wait_q <= WAIT_W'(`RA_RAM_WAIT - 1);
		end else if (ram_port.ack) begin
			busy_q <= 1'b0;
		end else if (busy_q) begin
			wait_q <= wait_q - 1'b1;
		end
	end

	// storage, write or read happens right at the accept
	always_ff @(posedge MAX10_CLK1_50) begin
		if (accept) begin
			if (ram_port.we)
				mem_q[ram_port.addr] <= ram_port.wdata;
			else
				rdata_q <= mem_q[ram_port.addr];
		end
	end

	assign ram_port.ack   = busy_q && (wait_q == '0);
	assign ram_port.rdata = rdata_q; // held until the next read

endmodule

// File: rhythm_audio.f
+incdir+logic
logic/rhythm_audio_pkg.sv
logic/mem_port_if.sv
logic/mem_arbiter.sv
logic/sample_ram.sv
logic/sample_fetcher.sv
logic/sample_fifo.sv
logic/i2s_serializer.sv
logic/rhythm_audio.sv
sim/tb_rhythm_audio.sv

// File: sim/tb_rhythm_audio.sv
// playback lengths 8..40 words; each play_start_i is given with the FIFO empty and the fetcher idle
`timescale 1ns/1ps
`include "rhythm_audio_params.svh"

module tb_rhythm_audio;

	localparam int DEPTH    = 2 ** `RA_ADDR_W;
	localparam int MAX_N    = 40; // longest playback
	localparam int N_RANDOM = 24; // scattered writes before playback
	localparam int N_LIVE   = 16; // writes while playing
	// loads at up to 24 cycles each, plus every frame of both playbacks
	localparam int LIMIT = (N_RANDOM + 2 * MAX_N + 2 * N_LIVE) * 24
		+ 2 * MAX_N * 32 * 2 * `RA_BCLK_HALF + 1000;

	logic MAX10_CLK1_50, reset_i, load_wr_i, load_ack_o, play_start_i;
	logic playing_o, i2s_bclk_o, i2s_lrclk_o, i2s_data_o;
	rhythm_audio_pkg::addr_t   load_addr_i, sample_count_i;
	rhythm_audio_pkg::sample_t load_data_i;

	rhythm_audio_pkg::sample_t model [DEPTH]; // mirror of every load write
	rhythm_audio_pkg::sample_t cap_word [$];  // words seen on the serial line
	logic                      cap_ch [$];    // 0 = left, 1 = right

	int cycle_cnt = 0;
	int error_cnt = 0;
	int write_cnt = 0;
	int ack_cnt   = 0;
	int frame_cnt = 0;
	bit play_seen = 0;

	// I2S receiver state
	rhythm_audio_pkg::sample_t shreg;
	int   bit_cnt = 0;
	logic prev_lr = 1'b0; // ws of the previous bit names the channel
	logic word_ch;

	rhythm_audio i_dut (.*);

	initial begin
		MAX10_CLK1_50 = 1'b0;
		forever #4 MAX10_CLK1_50 = ~MAX10_CLK1_50;
	end

	always @(posedge MAX10_CLK1_50) cycle_cnt <= cycle_cnt + 1;

	// ========================================
	// reporting and monitors
	// ========================================
	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		error_cnt++;
		$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic report_problem(input string msg);
		error_cnt++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	always @(negedge MAX10_CLK1_50) begin
		if (load_ack_o)
			ack_cnt++; // one per write expected
		if (!reset_i && !play_seen && playing_o !== 1'b0)
			report_mismatch("playing_o", playing_o, 0);
	end

	always @(posedge i2s_bclk_o) begin
		shreg = {shreg[`RA_SAMPLE_W-2:0], i2s_data_o}; // MSB first
		if (bit_cnt == 0)
			word_ch = prev_lr;
		prev_lr = i2s_lrclk_o;
		bit_cnt++;
		if (bit_cnt == `RA_SAMPLE_W) begin
			cap_word.push_back(shreg);
			cap_ch.push_back(word_ch);
			bit_cnt = 0;
		end
	end

	initial begin
		wait (cycle_cnt >= LIMIT);
		$display("timeout after %0d cycles, playback or a load never finished", cycle_cnt);
		$display("writes %0d, acks %0d, frames %0d, errors %0d", write_cnt, ack_cnt,
			frame_cnt, error_cnt + 1);
		$display("** FAIL **");
		$finish;
	end

	// ========================================
	// stimulus tasks
	// ========================================
	// called at posedge + 1, returns in the ack cycle
	task automatic load_word(input rhythm_audio_pkg::addr_t addr,
		input rhythm_audio_pkg::sample_t data);
		int waited;
		waited = 0;
		load_addr_i = addr;
		load_data_i = data;
		load_wr_i   = 1'b1; // held until ack
		model[addr] = data;
		write_cnt++;
		do begin
			@(posedge MAX10_CLK1_50);
			#1;
			waited++;
		end while (!load_ack_o && waited < 200);
		if (!load_ack_o)
			report_problem("load_ack_o never came for a held write");
		load_wr_i = 1'b0;
	endtask

	task automatic play_and_check(input int n);
		play_seen = 1;
		cap_word.delete();
		cap_ch.delete();
		sample_count_i = rhythm_audio_pkg::addr_t'(n);
		play_start_i   = 1'b1;
		@(posedge MAX10_CLK1_50);
		#1;
		play_start_i = 1'b0;
		if (playing_o !== 1'b1)
			report_mismatch("playing_o", playing_o, 1);
		fork
			begin // loader traffic above the played range
				for (int i = 0; i < N_LIVE; i++) begin
					repeat ($urandom % 16) begin
						@(posedge MAX10_CLK1_50);
						#1;
					end
					load_word(rhythm_audio_pkg::addr_t'(n + $urandom % (DEPTH - n)),
						rhythm_audio_pkg::sample_t'($urandom));
				end
			end
			begin
				while (playing_o === 1'b1) begin
					@(posedge MAX10_CLK1_50);
					#1;
				end
			end
		join
		frame_cnt += cap_word.size() / 2; // frames actually seen on the line
		if (cap_word.size() != 2 * n)
			report_mismatch("captured word count", cap_word.size(), 2 * n);
		for (int k = 0; k < cap_word.size(); k++) begin
			if (cap_word[k] !== model[k / 2])
				report_mismatch("i2s_data_o word", cap_word[k], model[k / 2]);
			if (cap_ch[k] !== k[0])
				report_mismatch("i2s_lrclk_o", cap_ch[k], k[0]);
		end
		if (i2s_bclk_o !== 1'b0)
			report_mismatch("i2s_bclk_o", i2s_bclk_o, 0); // line quiet after stop
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		int n;
		void'($urandom(32'h1239_2cf3));
		reset_i        = 1'b1;
		load_wr_i      = 1'b0;
		load_addr_i    = '0;
		load_data_i    = '0;
		play_start_i   = 1'b0;
		sample_count_i = '0;
		repeat (8) @(posedge MAX10_CLK1_50);
		#1;
		reset_i = 1'b0;

		// outputs quiet after reset
		if (load_ack_o !== 1'b0)  report_mismatch("load_ack_o", load_ack_o, 0);
		if (playing_o !== 1'b0)   report_mismatch("playing_o", playing_o, 0);
		if (i2s_bclk_o !== 1'b0)  report_mismatch("i2s_bclk_o", i2s_bclk_o, 0);
		if (i2s_lrclk_o !== 1'b0) report_mismatch("i2s_lrclk_o", i2s_lrclk_o, 0);
		if (i2s_data_o !== 1'b0)  report_mismatch("i2s_data_o", i2s_data_o, 0);

		for (int i = 0; i < N_RANDOM; i++)
			load_word(rhythm_audio_pkg::addr_t'($urandom), rhythm_audio_pkg::sample_t'($urandom));

		// two playbacks, each from freshly loaded words 0..n-1
		repeat (2) begin
			n = 8 + $urandom % (MAX_N - 7);
			for (int a = 0; a < n; a++)
				load_word(rhythm_audio_pkg::addr_t'(a), rhythm_audio_pkg::sample_t'($urandom));
			play_and_check(n);
		end

		repeat (4) @(posedge MAX10_CLK1_50); // let the last ack be counted
		if (ack_cnt != write_cnt)
			report_mismatch("load_ack_o pulses", ack_cnt, write_cnt);
		$display("writes %0d, acks %0d, frames %0d, errors %0d", write_cnt, ack_cnt,
			frame_cnt, error_cnt);
		if (error_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
